//--- common/trap_pkg.sv
// machine mode only; 32-bit mtime and mtimecmp, word-addressed bus with no byte selects
package trap_pkg;

    typedef logic [31:0] xlen_t;     // data word
    typedef logic [31:0] addr_t;     // instruction address
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0]  wb_addr_t;  // word offset on the bus
    typedef logic [31:0] cause_t;    // bit 31 flags an interrupt

    // standard machine csr addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;
    localparam csr_addr_t CSR_MTVAL   = 12'h343;

    // synchronous exception codes
    localparam cause_t CAUSE_FETCH_MISALIGN = 32'd0;
    localparam cause_t CAUSE_ILLEGAL        = 32'd2;
    localparam cause_t CAUSE_BREAK          = 32'd3;
    localparam cause_t CAUSE_LOAD_MISALIGN  = 32'd4;
    localparam cause_t CAUSE_STORE_MISALIGN = 32'd6;
    localparam cause_t CAUSE_ECALL_M        = 32'd11;

    // interrupt codes, interrupt flag added by the decoder
    localparam cause_t CAUSE_INT_SOFT  = 32'd3;
    localparam cause_t CAUSE_INT_TIMER = 32'd7;
    localparam cause_t CAUSE_INT_EXT   = 32'd11;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_MSIE_BIT     = 3;
    localparam int MIE_MTIE_BIT     = 7;
    localparam int MIE_MEIE_BIT     = 11;

    // clint word offsets
    localparam wb_addr_t CLINT_MSIP     = 4'd0;
    localparam wb_addr_t CLINT_MTIMECMP = 4'd1;
    localparam wb_addr_t CLINT_MTIME    = 4'd2;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PENDING,
        ST_MEPC,
        ST_MSTATUS,
        ST_MTVAL,
        ST_MCAUSE,
        ST_MRET
    } trap_state_e;

endpackage

//--- trap/trap_decode.sv
// purely combinational; cause_o and epc_o are meaningful only while take_o is high
`timescale 1ns/1ps

module trap_decode (
    input  logic             inst_valid_i,
    input  trap_pkg::addr_t  inst_addr_i,
    input  trap_pkg::xlen_t  inst_data_i,
    input  logic             jump_flag_i,
    input  trap_pkg::addr_t  jump_addr_i,
    input  logic             ecall_i,
    input  logic             ebreak_i,
    input  logic             fetch_misalign_i,
    input  logic             load_misalign_i,
    input  logic             store_misalign_i,
    input  logic             illegal_i,
    input  logic             ext_irq_i,
    input  logic             timer_irq_i,
    input  logic             soft_irq_i,
    input  trap_pkg::xlen_t  mstatus_i,
    input  trap_pkg::xlen_t  mie_i,
    output logic             take_o,
    output logic             is_int_o,
    output trap_pkg::cause_t cause_o,
    output trap_pkg::addr_t  epc_o,
    output trap_pkg::xlen_t  mtval_o,
    output logic             mtval_en_o
);
    import trap_pkg::*;

    logic   exc_load;   // these three are squashed by a taken jump
    logic   exc_store;
    logic   exc_illegal;
    logic   int_ext;
    logic   int_timer;
    logic   int_soft;
    logic   any_exc;
    logic   any_int;
    cause_t exc_cause;
    cause_t int_cause;

    assign exc_load    = load_misalign_i & ~jump_flag_i;
    assign exc_store   = store_misalign_i & ~jump_flag_i;
    assign exc_illegal = illegal_i & ~jump_flag_i;

    // interrupts need both the local enable and global mstatus.MIE
    assign int_ext   = ext_irq_i & mie_i[MIE_MEIE_BIT] & mstatus_i[MSTATUS_MIE_BIT];
    assign int_timer = timer_irq_i & mie_i[MIE_MTIE_BIT] & mstatus_i[MSTATUS_MIE_BIT];
    assign int_soft  = soft_irq_i & mie_i[MIE_MSIE_BIT] & mstatus_i[MSTATUS_MIE_BIT];

    assign any_exc = ecall_i | ebreak_i | fetch_misalign_i | exc_load | exc_store | exc_illegal;
    assign any_int = int_ext | int_timer | int_soft;

    assign exc_cause = ecall_i          ? CAUSE_ECALL_M :
                       ebreak_i         ? CAUSE_BREAK :
                       fetch_misalign_i ? CAUSE_FETCH_MISALIGN :
                       exc_load         ? CAUSE_LOAD_MISALIGN :
                       exc_store        ? CAUSE_STORE_MISALIGN :
                                          CAUSE_ILLEGAL;
    assign int_cause = int_ext   ? CAUSE_INT_EXT :
                       int_timer ? CAUSE_INT_TIMER :
                                   CAUSE_INT_SOFT;

    assign take_o   = inst_valid_i & (any_exc | any_int);
    assign is_int_o = ~any_exc & any_int;  // exceptions always win
    assign cause_o  = any_exc ? exc_cause : {1'b1, int_cause[30:0]};

    // an interrupt resumes at the next instruction or at the jump target
    assign epc_o = any_exc     ? inst_addr_i :
                   jump_flag_i ? jump_addr_i :
                                 inst_addr_i + 32'd4;

    // only the lower-ranked load, store and illegal causes record the instruction
    assign mtval_en_o = any_exc & ~ecall_i & ~ebreak_i & ~fetch_misalign_i;
    assign mtval_o    = mtval_en_o ? inst_data_i : '0;

endmodule

//--- trap/trap_sequencer.sv
// requests seen while busy are dropped; the pipeline must flush on redirect_o
`timescale 1ns/1ps

module trap_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                take_i,
    input  logic                is_int_i,
    input  trap_pkg::cause_t    cause_i,
    input  trap_pkg::addr_t     epc_i,
    input  trap_pkg::xlen_t     mtval_i,
    input  logic                mtval_en_i,
    input  logic                mret_i,
    input  logic                hold_i,
    input  logic                jump_flag_i,
    input  trap_pkg::addr_t     jump_addr_i,
    input  trap_pkg::xlen_t     mstatus_i,
    input  trap_pkg::xlen_t     mtvec_i,
    input  trap_pkg::addr_t     mepc_i,
    output logic                redirect_o,
    output trap_pkg::addr_t     redirect_addr_o,
    output logic                busy_o,
    output logic                tw_we_o,
    output trap_pkg::csr_addr_t tw_addr_o,
    output trap_pkg::xlen_t     tw_data_o
);
    import trap_pkg::*;

    trap_state_e state_q;
    trap_state_e state_d;
    logic        mret_q;     // pending request is an mret
    logic        is_int_q;
    logic        mtval_en_q;
    logic        accept;
    logic        go;         // leaving PENDING at this edge
    cause_t      cause_q;
    addr_t       epc_q;
    xlen_t       mtval_q;
    addr_t       vec_base;
    addr_t       target;

    assign accept = (state_q == ST_IDLE) & (take_i | mret_i);
    assign go     = (state_q == ST_PENDING) & ~hold_i;
    assign busy_o = (state_q != ST_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (take_i || mret_i) begin
                    state_d = ST_PENDING;
                end
            end
            ST_PENDING: begin
                if (!hold_i) begin
                    state_d = mret_q ? ST_MRET : ST_MEPC;
                end
            end
            ST_MEPC:    state_d = ST_MSTATUS;
            ST_MSTATUS: state_d = mtval_en_q ? ST_MTVAL : ST_MCAUSE;
            ST_MTVAL:   state_d = ST_MCAUSE;
            default:    state_d = ST_IDLE;  // MCAUSE and MRET finish here
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            mret_q     <= 1'b0;
            is_int_q   <= 1'b0;
            mtval_en_q <= 1'b0;
            redirect_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            redirect_o <= go;  // single pulse, PENDING is left right away
            if (accept) begin
                mret_q     <= ~take_i;  // a trap beats an mret in the same cycle
                is_int_q   <= is_int_i;
                mtval_en_q <= mtval_en_i;
            end
        end
    end

    // trap record and jump target
    always_ff @(posedge clk) begin
        if (accept && take_i) begin
            cause_q <= cause_i;
            epc_q   <= epc_i;
            mtval_q <= mtval_i;
        end else if (state_q == ST_PENDING && jump_flag_i) begin
            epc_q <= jump_addr_i;  // jump resolved during the hold
        end
        if (go) begin
            redirect_addr_o <= target;
        end
    end

    assign vec_base = {mtvec_i[31:2], 2'b00};

    // vectored mode only offsets interrupts
    assign target = mret_q                  ? mepc_i :
                    (is_int_q && mtvec_i[0]) ? vec_base + {cause_q[29:0], 2'b00} :
                                               vec_base;

    // one csr write per state, stored at the edge that leaves it
    always_comb begin
        tw_we_o   = 1'b0;
        tw_addr_o = CSR_MCAUSE;
        tw_data_o = '0;
        case (state_q)
            ST_MEPC: begin
                tw_we_o   = 1'b1;
                tw_addr_o = CSR_MEPC;
                tw_data_o = epc_q;
            end
            ST_MSTATUS: begin
                tw_we_o   = 1'b1;
                tw_addr_o = CSR_MSTATUS;
                tw_data_o = mstatus_i;
                tw_data_o[MSTATUS_MPIE_BIT] = mstatus_i[MSTATUS_MIE_BIT];
                tw_data_o[MSTATUS_MIE_BIT]  = 1'b0;
            end
            ST_MTVAL: begin
                tw_we_o   = 1'b1;
                tw_addr_o = CSR_MTVAL;
                tw_data_o = mtval_q;
            end
            ST_MCAUSE: begin
                tw_we_o   = 1'b1;
                tw_data_o = cause_q;
            end
            ST_MRET: begin
                tw_we_o   = 1'b1;
                tw_addr_o = CSR_MSTATUS;
                tw_data_o = mstatus_i;
                tw_data_o[MSTATUS_MIE_BIT]  = mstatus_i[MSTATUS_MPIE_BIT];
                tw_data_o[MSTATUS_MPIE_BIT] = 1'b1;
            end
            default: begin
                tw_we_o = 1'b0;  // idle or waiting
            end
        endcase
    end

endmodule

//--- rtl/mcsr_file.sv
// six full-width machine csrs with no field masking; unknown addresses read as zero
`timescale 1ns/1ps

module mcsr_file (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tw_we_i,
    input  trap_pkg::csr_addr_t tw_addr_i,
    input  trap_pkg::xlen_t     tw_data_i,
    input  logic                csr_we_i,
    input  trap_pkg::csr_addr_t csr_waddr_i,
    input  trap_pkg::xlen_t     csr_wdata_i,
    input  trap_pkg::csr_addr_t csr_raddr_i,
    output trap_pkg::xlen_t     csr_rdata_o,
    output trap_pkg::xlen_t     mstatus_o,
    output trap_pkg::xlen_t     mie_o,
    output trap_pkg::xlen_t     mtvec_o,
    output trap_pkg::addr_t     mepc_o
);
    import trap_pkg::*;

    xlen_t     mstatus_q;
    xlen_t     mie_q;
    xlen_t     mtvec_q;
    xlen_t     mepc_q;
    xlen_t     mcause_q;
    xlen_t     mtval_q;
    logic      we;
    csr_addr_t waddr;
    xlen_t     wdata;

    // trap port wins over the pipeline port
    assign we    = tw_we_i | csr_we_i;
    assign waddr = tw_we_i ? tw_addr_i : csr_waddr_i;
    assign wdata = tw_we_i ? tw_data_i : csr_wdata_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mtval_q   <= '0;
        end else if (we) begin
            case (waddr)
                CSR_MSTATUS: mstatus_q <= wdata;
                CSR_MIE:     mie_q     <= wdata;
                CSR_MTVEC:   mtvec_q   <= wdata;
                CSR_MEPC:    mepc_q    <= wdata;
                CSR_MCAUSE:  mcause_q  <= wdata;
                CSR_MTVAL:   mtval_q   <= wdata;
                default:     ;  // write to an unimplemented csr is dropped
            endcase
        end
    end

    always_comb begin
        case (csr_raddr_i)
            CSR_MSTATUS: csr_rdata_o = mstatus_q;
            CSR_MIE:     csr_rdata_o = mie_q;
            CSR_MTVEC:   csr_rdata_o = mtvec_q;
            CSR_MEPC:    csr_rdata_o = mepc_q;
            CSR_MCAUSE:  csr_rdata_o = mcause_q;
            CSR_MTVAL:   csr_rdata_o = mtval_q;
            default:     csr_rdata_o = '0;
        endcase
    end

    assign mstatus_o = mstatus_q;
    assign mie_o     = mie_q;
    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;

endmodule

//--- rtl/clint_regs.sv
// wishbone classic, full-word writes only; 32-bit mtime compare does not handle wrap
`timescale 1ns/1ps

module clint_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  trap_pkg::wb_addr_t wb_adr_i,
    input  trap_pkg::xlen_t    wb_dat_i,
    output trap_pkg::xlen_t    wb_dat_o,
    output logic               wb_ack_o,
    output logic               timer_irq_o,
    output logic               soft_irq_o
);
    import trap_pkg::*;

    logic  msip_q;
    xlen_t mtime_q;
    xlen_t mtimecmp_q;
    xlen_t rdata;
    logic  req;  // request not yet acknowledged
    logic  wr;

    // ack is low again the cycle after it pulses, even if stb stays up
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr  = req & wb_we_i;

    always_comb begin
        case (wb_adr_i)
            CLINT_MSIP:     rdata = {31'b0, msip_q};
            CLINT_MTIMECMP: rdata = mtimecmp_q;
            CLINT_MTIME:    rdata = mtime_q;
            default:        rdata = '0;  // unmapped, still acked
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack_o   <= 1'b0;
            msip_q     <= 1'b0;
            mtimecmp_q <= '1;  // no timer interrupt until programmed
            mtime_q    <= '0;
        end else begin
            wb_ack_o <= req;
            if (wr && wb_adr_i == CLINT_MSIP) begin
                msip_q <= wb_dat_i[0];
            end
            if (wr && wb_adr_i == CLINT_MTIMECMP) begin
                mtimecmp_q <= wb_dat_i;
            end
            // a bus write replaces this cycle's increment
            if (wr && wb_adr_i == CLINT_MTIME) begin
                mtime_q <= wb_dat_i;
            end else begin
                mtime_q <= mtime_q + 32'd1;
            end
        end
    end

    // read data lands together with ack
    always_ff @(posedge clk) begin
        if (req && !wb_we_i) begin
            wb_dat_o <= rdata;
        end
    end

    assign timer_irq_o = (mtime_q >= mtimecmp_q);  // unsigned compare
    assign soft_irq_o  = msip_q;

endmodule

//--- rtl/trap_unit_top.sv
// single clock domain; the pipeline flushes on redirect_o and drives hold_i for atomics
`timescale 1ns/1ps

module trap_unit_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid_i,
    input  trap_pkg::addr_t     inst_addr_i,
    input  trap_pkg::xlen_t     inst_data_i,
    input  logic                jump_flag_i,
    input  trap_pkg::addr_t     jump_addr_i,
    input  logic                ecall_i,
    input  logic                ebreak_i,
    input  logic                fetch_misalign_i,
    input  logic                load_misalign_i,
    input  logic                store_misalign_i,
    input  logic                illegal_i,
    input  logic                mret_i,
    input  logic                ext_irq_i,
    input  logic                hold_i,
    input  logic                csr_we_i,
    input  trap_pkg::csr_addr_t csr_waddr_i,
    input  trap_pkg::xlen_t     csr_wdata_i,
    input  trap_pkg::csr_addr_t csr_raddr_i,
    output trap_pkg::xlen_t     csr_rdata_o,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  trap_pkg::wb_addr_t  wb_adr_i,
    input  trap_pkg::xlen_t     wb_dat_i,
    output trap_pkg::xlen_t     wb_dat_o,
    output logic                wb_ack_o,
    output logic                redirect_o,
    output trap_pkg::addr_t     redirect_addr_o,
    output logic                busy_o
);
    import trap_pkg::*;

    logic      take;
    logic      is_int;
    cause_t    cause;
    addr_t     epc;
    xlen_t     mtval;
    logic      mtval_en;
    logic      tw_we;
    csr_addr_t tw_addr;
    xlen_t     tw_data;
    xlen_t     mstatus;
    xlen_t     mie;
    xlen_t     mtvec;
    addr_t     mepc;
    logic      timer_irq;
    logic      soft_irq;

    trap_decode u_decode (
        .inst_valid_i     (inst_valid_i),
        .inst_addr_i      (inst_addr_i),
        .inst_data_i      (inst_data_i),
        .jump_flag_i      (jump_flag_i),
        .jump_addr_i      (jump_addr_i),
        .ecall_i          (ecall_i),
        .ebreak_i         (ebreak_i),
        .fetch_misalign_i (fetch_misalign_i),
        .load_misalign_i  (load_misalign_i),
        .store_misalign_i (store_misalign_i),
        .illegal_i        (illegal_i),
        .ext_irq_i        (ext_irq_i),
        .timer_irq_i      (timer_irq),
        .soft_irq_i       (soft_irq),
        .mstatus_i        (mstatus),
        .mie_i            (mie),
        .take_o           (take),
        .is_int_o         (is_int),
        .cause_o          (cause),
        .epc_o            (epc),
        .mtval_o          (mtval),
        .mtval_en_o       (mtval_en)
    );

    trap_sequencer u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .take_i          (take),
        .is_int_i        (is_int),
        .cause_i         (cause),
        .epc_i           (epc),
        .mtval_i         (mtval),
        .mtval_en_i      (mtval_en),
        .mret_i          (mret_i),
        .hold_i          (hold_i),
        .jump_flag_i     (jump_flag_i),
        .jump_addr_i     (jump_addr_i),
        .mstatus_i       (mstatus),
        .mtvec_i         (mtvec),
        .mepc_i          (mepc),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o),
        .busy_o          (busy_o),
        .tw_we_o         (tw_we),
        .tw_addr_o       (tw_addr),
        .tw_data_o       (tw_data)
    );

    mcsr_file u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .tw_we_i     (tw_we),
        .tw_addr_i   (tw_addr),
        .tw_data_i   (tw_data),
        .csr_we_i    (csr_we_i),
        .csr_waddr_i (csr_waddr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_raddr_i (csr_raddr_i),
        .csr_rdata_o (csr_rdata_o),
        .mstatus_o   (mstatus),
        .mie_o       (mie),
        .mtvec_o     (mtvec),
        .mepc_o      (mepc)
    );

    clint_regs u_clint (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .timer_irq_o (timer_irq),
        .soft_irq_o  (soft_irq)
    );

endmodule

//--- verif/trap_unit_asserts.sv
// port-level checks only; a failing property raises $error and latches the violation flag
`timescale 1ns/1ps

module trap_unit_asserts (
    input logic clk,
    input logic rst_n,
    input logic redirect_i,
    input logic busy_i,
    input logic hold_i,
    input logic take_i,
    input logic mret_i,
    input logic tw_we_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i
);
    logic bad_pulse = 1'b0;
    logic bad_tw = 1'b0;
    logic bad_ack_len = 1'b0;
    logic bad_ack_cyc = 1'b0;
    logic bad_latency = 1'b0;
    logic violation;
    logic accept;

    assign accept    = !busy_i && (take_i || mret_i);  // sequencer leaves idle at this edge
    assign violation = bad_pulse | bad_tw | bad_ack_len | bad_ack_cyc | bad_latency;

    a_redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_i |=> !redirect_i)
        else begin
            $error("redirect_o stayed high for more than one cycle");
            bad_pulse = 1'b1;
        end

    a_no_idle_write: assert property (@(posedge clk) disable iff (!rst_n)
        tw_we_i |-> busy_i)
        else begin
            $error("trap csr write while the sequencer is idle");
            bad_tw = 1'b1;
        end

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_i |=> !wb_ack_i)
        else begin
            $error("wb_ack_o longer than one cycle");
            bad_ack_len = 1'b1;
        end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else begin
            $error("wb_ack_o outside a bus cycle");
            bad_ack_cyc = 1'b1;
        end

    // accept, one edge with hold low, then the pulse
    a_redirect_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(accept, 2) && !$past(hold_i)) |-> redirect_i)
        else begin
            $error("redirect_o late after an accepted request");
            bad_latency = 1'b1;
        end

endmodule

bind trap_unit_top trap_unit_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_o),
    .busy_i     (busy_o),
    .hold_i     (hold_i),
    .take_i     (take),
    .mret_i     (mret_i),
    .tw_we_i    (tw_we),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_ack_i   (wb_ack_o)
);

//--- verif/tb_trap_unit.sv
// drives on falling edges, stops at the first mismatch; needs assertions enabled in the simulator
`timescale 1ns/1ps

module tb_trap_unit;
    import trap_pkg::*;

    localparam int MAX_CYCLES = 3000;  // full run needs roughly 1200

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_valid_i, jump_flag_i, mret_i, ext_irq_i, hold_i;
    addr_t       inst_addr_i, jump_addr_i;
    xlen_t       inst_data_i;
    logic        ecall_i, ebreak_i, fetch_misalign_i, load_misalign_i, store_misalign_i;
    logic        illegal_i;
    logic [5:0]  exc;  // {ecall, ebreak, fetch, load, store, illegal}
    logic        csr_we_i;
    csr_addr_t   csr_waddr_i, csr_raddr_i;
    xlen_t       csr_wdata_i, csr_rdata_o;
    logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    wb_addr_t    wb_adr_i;
    xlen_t       wb_dat_i, wb_dat_o;
    logic        redirect_o, busy_o;
    addr_t       redirect_addr_o;
    logic [31:0] seed = 32'hc217_d1ed;
    int          cycles = 0;

    assign {ecall_i, ebreak_i, fetch_misalign_i, load_misalign_i, store_misalign_i, illegal_i} = exc;

    trap_unit_top uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            abort_run("timeout, the run did not finish within the cycle limit");
        end
    end

    always @(negedge clk) begin
        if (uut.u_asserts.violation) begin
            abort_run("a bound assertion failed");
        end
    end

    task automatic abort_run(input string why);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", why);
    endtask

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // exception ranking, flags already masked by the jump rule
    function automatic cause_t exc_code(input logic [5:0] f);
        return f[5] ? CAUSE_ECALL_M : f[4] ? CAUSE_BREAK : f[3] ? CAUSE_FETCH_MISALIGN :
               f[2] ? CAUSE_LOAD_MISALIGN : f[1] ? CAUSE_STORE_MISALIGN : CAUSE_ILLEGAL;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_not_below(input string name, input logic [31:0] got,
                                   input logic [31:0] low);
        assert (got >= low) else begin
            $display("[ERROR] %s is 0x%08h, below 0x%08h", name, got, low);
            abort_run("value below its lower bound");
        end
    endtask

    task automatic csr_write(input csr_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        csr_we_i    = 1'b1;
        csr_waddr_i = addr;
        csr_wdata_i = data;
        @(negedge clk);
        csr_we_i = 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t addr, output logic [31:0] data);
        @(negedge clk);
        csr_raddr_i = addr;
        #1 data = csr_rdata_o;
    endtask

    // request stays up through the ack edge
    task automatic wb_access(input logic we, input wb_addr_t adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited = 0;
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 8) begin
                abort_run("no Wishbone ack for a bus request");
            end
        end while (!wb_ack_o);
        rdata = wb_dat_o;
        @(negedge clk);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic issue_inst(input logic [5:0] f, input logic jmp, input logic [31:0] ia,
                              input logic [31:0] idata, input logic [31:0] ja);
        @(negedge clk);
        inst_valid_i = 1'b1;
        exc          = f;
        jump_flag_i  = jmp;
        inst_addr_i  = ia;
        inst_data_i  = idata;
        jump_addr_i  = ja;
        @(negedge clk);
        inst_valid_i = 1'b0;
        exc          = 6'b0;
        jump_flag_i  = 1'b0;
    endtask

    task automatic expect_redirect(input string name, input logic [31:0] target);
        int waited = 0;
        while (!redirect_o) begin
            @(negedge clk);
            waited++;
            if (waited > 16) begin
                abort_run("redirect_o never pulsed after a request");
            end
        end
        check_value(name, redirect_addr_o, target);
        while (busy_o) begin
            @(negedge clk);
        end
    endtask

    // trap record, mstatus stacking, then mret back to mepc
    task automatic finish_trap(input logic [31:0] target, input logic [31:0] epc,
                               input logic [31:0] cause, input logic [31:0] tval,
                               input logic tv, input logic [31:0] old_ms);
        logic [31:0] rd;
        logic [31:0] stacked;
        logic [31:0] restored;
        stacked                   = old_ms;
        stacked[MSTATUS_MPIE_BIT] = old_ms[MSTATUS_MIE_BIT];
        stacked[MSTATUS_MIE_BIT]  = 1'b0;
        restored                   = stacked;
        restored[MSTATUS_MIE_BIT]  = stacked[MSTATUS_MPIE_BIT];
        restored[MSTATUS_MPIE_BIT] = 1'b1;
        expect_redirect("redirect_addr_o", target);
        csr_read(CSR_MEPC, rd);
        check_value("mepc", rd, epc);
        csr_read(CSR_MCAUSE, rd);
        check_value("mcause", rd, cause);
        if (tv) begin
            csr_read(CSR_MTVAL, rd);
            check_value("mtval", rd, tval);
        end
        csr_read(CSR_MSTATUS, rd);
        check_value("mstatus after trap", rd, stacked);
        @(negedge clk);
        mret_i = 1'b1;
        @(negedge clk);
        mret_i = 1'b0;
        expect_redirect("redirect_addr_o on mret", epc);
        csr_read(CSR_MSTATUS, rd);
        check_value("mstatus after mret", rd, restored);
    endtask

    initial begin
        logic [31:0] r, base, ia, ja, idata, t0, t1, rd, target;
        cause_t      code;
        logic [5:0]  f, eff;
        logic [2:0]  src, en, q;  // {ext, timer, soft}
        logic        jmp, gie;
        int          n;
        int          waited;
        rst_n        = 1'b0;
        inst_valid_i = 1'b0;
        inst_addr_i  = '0;
        inst_data_i  = '0;
        jump_flag_i  = 1'b0;
        jump_addr_i  = '0;
        exc          = 6'b0;
        mret_i       = 1'b0;
        ext_irq_i    = 1'b0;
        hold_i       = 1'b0;
        csr_we_i     = 1'b0;
        csr_waddr_i  = '0;
        csr_wdata_i  = '0;
        csr_raddr_i  = '0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        csr_read(CSR_MCAUSE, rd);
        check_value("mcause after reset", rd, 32'h0);
        wb_access(1'b0, CLINT_MTIMECMP, 32'h0, rd);
        check_value("mtimecmp after reset", rd, 32'hffff_ffff);
        wb_access(1'b0, 4'hf, 32'h0, rd);
        check_value("unmapped bus read", rd, 32'h0);

        // random exception combinations, interrupts masked by mie = 0
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            base = {r[31:8], 8'h00};
            csr_write(CSR_MTVEC, {r[31:8], 7'b0, r[0]});  // mode does not move exceptions
            csr_write(CSR_MSTATUS, {28'b0, r[1], 3'b0});
            f = (r[7:2] == 6'b0) ? 6'b100000 : r[7:2];
            jmp = r[8];
            eff = jmp ? (f & 6'b111000) : f;
            ia = next_rand() & 32'hffff_fffc;
            idata = next_rand();
            issue_inst(f, jmp, ia, idata, ia + 32'd8);
            check_value("busy_o", {31'b0, busy_o}, {31'b0, |eff});
            if (|eff) begin
                finish_trap(base, ia, exc_code(eff), idata, ~|eff[5:3], {28'b0, r[1], 3'b0});
            end
        end

        // interrupt masking and ranking, first round is msip alone
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            src = (i == 0) ? 3'b001 : r[2:0];
            en = (i == 0) ? 3'b111 : r[5:3];
            gie = (i == 0) ? 1'b1 : (r[7:6] != 2'b00);
            base = {r[31:8], 8'h00};
            csr_write(CSR_MTVEC, {r[31:8], 7'b0, r[8]});
            csr_write(CSR_MIE, {20'b0, en[2], 3'b0, en[1], 3'b0, en[0], 3'b0});
            csr_write(CSR_MSTATUS, {28'b0, gie, 3'b0});
            wb_access(1'b1, CLINT_MSIP, {31'b0, src[0]}, rd);
            wb_access(1'b0, CLINT_MSIP, 32'h0, rd);
            check_value("msip", rd, {31'b0, src[0]});
            wb_access(1'b1, CLINT_MTIMECMP, src[1] ? 32'h0 : 32'hffff_ffff, rd);
            ext_irq_i = src[2];
            q = src & en & {3{gie}};
            jmp = r[9];
            ia = next_rand() & 32'hffff_fffc;
            ja = next_rand() & 32'hffff_fffc;
            issue_inst(6'b0, jmp, ia, 32'h0, ja);
            check_value("busy_o", {31'b0, busy_o}, {31'b0, |q});
            if (|q) begin
                code = q[2] ? CAUSE_INT_EXT : q[1] ? CAUSE_INT_TIMER : CAUSE_INT_SOFT;
                target = r[8] ? base + (code << 2) : base;
                finish_trap(target, jmp ? ja : ia + 32'd4, {1'b1, code[30:0]}, 32'h0, 1'b0,
                             {28'b0, gie, 3'b0});
            end
        end
        ext_irq_i = 1'b0;
        wb_access(1'b1, CLINT_MSIP, 32'h0, rd);
        wb_access(1'b1, CLINT_MTIMECMP, 32'hffff_ffff, rd);

        // ecall under hold, a jump during the wait moves mepc
        base = next_rand() & 32'hffff_ff00;
        csr_write(CSR_MTVEC, base);
        csr_write(CSR_MSTATUS, 32'h8);
        r = next_rand();
        n = 2 + int'(r[2:0]);
        ia = next_rand() & 32'hffff_fffc;
        ja = ia;
        @(negedge clk);
        hold_i = 1'b1;
        issue_inst(6'b100000, 1'b0, ia, 32'h0, 32'h0);
        for (int k = 0; k < n; k++) begin
            check_value("redirect_o", {31'b0, redirect_o}, 32'h0);
            jump_flag_i = (k == 1);
            if (k == 1) begin
                ja = next_rand() & 32'hffff_fffc;
                jump_addr_i = ja;
            end
            @(negedge clk);
        end
        jump_flag_i = 1'b0;
        hold_i = 1'b0;
        finish_trap(base, ja, CAUSE_ECALL_M, 32'h0, 1'b0, 32'h8);

        // mtime monotonic, timer trap once mtime reaches mtimecmp
        wb_access(1'b0, CLINT_MTIME, 32'h0, t0);
        wb_access(1'b0, CLINT_MTIME, 32'h0, t1);
        check_not_below("mtime", t1, t0);
        wb_access(1'b1, CLINT_MTIMECMP, t1 + 32'd30, rd);
        wb_access(1'b0, CLINT_MTIMECMP, 32'h0, rd);
        check_value("mtimecmp", rd, t1 + 32'd30);
        csr_write(CSR_MIE, 32'h80);
        csr_write(CSR_MSTATUS, 32'h8);
        wb_access(1'b0, CLINT_MTIME, 32'h0, t0);
        ia = next_rand() & 32'hffff_fffc;
        waited = 0;
        @(negedge clk);
        inst_valid_i = 1'b1;
        inst_addr_i  = ia;
        while (!busy_o) begin
            @(negedge clk);  // cycle limit bounds this wait
            waited++;
        end
        inst_valid_i = 1'b0;
        // the trap waits until mtime has climbed from t0 to mtimecmp, give or take bus overhead
        check_not_below("mtime at timer trap", t0 + waited + 32'd4, t1 + 32'd30);
        finish_trap(base, ia + 32'd4, 32'h8000_0000 | CAUSE_INT_TIMER, 32'h0, 1'b0, 32'h8);
        wb_access(1'b1, CLINT_MTIMECMP, 32'hffff_ffff, rd);

        repeat (4) @(negedge clk);
        if (!uut.u_asserts.violation) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("a bound assertion failed");
        end
    end

endmodule

//--- sources.f
common/trap_pkg.sv
trap/trap_decode.sv
trap/trap_sequencer.sv
rtl/mcsr_file.sv
rtl/clint_regs.sv
rtl/trap_unit_top.sv
verif/trap_unit_asserts.sv
verif/tb_trap_unit.sv

//--- run.sh
#!/bin/sh
# build and run the trap unit testbench; exit status follows the simulation result
verilator --binary --timing --assert -j 0 --top-module tb_trap_unit -f sources.f \
    && ./obj_dir/Vtb_trap_unit +verilator+error+limit+100 \
    || exit 1
